/* Bender.yml */
package:
  name: ds1302_rtc

sources:
  - src/ds_pkg.sv
  - src/ds_function.sv
  - src/ds_control.sv
  - src/ds1302_rtc.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/ds1302_model.sv
      - verif/ds1302_rtc_props.sv
      - verif/ds1302_rtc_tb.sv

/* ds1302_rtc.f */
src/ds_pkg.sv
src/ds_function.sv
src/ds_control.sv
src/ds1302_rtc.sv
verif/tb_clock_gen.sv
verif/ds1302_model.sv
verif/ds1302_rtc_props.sv
verif/ds1302_rtc_tb.sv

/* src/ds1302_rtc.sv */
module ds1302_rtc
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_write,
    input  logic       req_read,
    input  logic [4:0] req_addr,
    input  logic [7:0] req_wdata,
    output logic       busy,
    output logic [7:0] req_rdata,
    output logic       rdata_valid,
    output logic [7:0] seconds,
    output logic [7:0] minutes,
    output logic [7:0] hours,
    output logic       time_valid,
    output logic       sclk,
    output logic       ce,
    inout  wire        sio
);

    logic [1:0] func_start;     // one-hot level, held until func_done
    logic [7:0] register_addr;  // full command byte
    logic [7:0] write_data;
    logic       func_done;
    logic [7:0] read_data;

    ds_control ds_control_i
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_write     (req_write),
        .req_read      (req_read),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .func_done     (func_done),
        .read_data     (read_data),
        .busy          (busy),
        .req_rdata     (req_rdata),
        .rdata_valid   (rdata_valid),
        .seconds       (seconds),
        .minutes       (minutes),
        .hours         (hours),
        .time_valid    (time_valid),
        .func_start    (func_start),
        .register_addr (register_addr),
        .write_data    (write_data)
    );

    ds_function ds_function_i
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .func_start    (func_start),
        .register_addr (register_addr),
        .write_data    (write_data),
        .func_done     (func_done),
        .read_data     (read_data),
        .sclk          (sclk),
        .ce            (ce),
        .sio           (sio)
    );

endmodule

/* src/ds_control.sv */
module ds_control
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_write,
    input  logic       req_read,
    input  logic [4:0] req_addr,
    input  logic [7:0] req_wdata,
    input  logic       func_done,
    input  logic [7:0] read_data,
    output logic       busy,
    output logic [7:0] req_rdata,
    output logic       rdata_valid,
    output logic [7:0] seconds,
    output logic [7:0] minutes,
    output logic [7:0] hours,
    output logic       time_valid,
    output logic [1:0] func_start,
    output logic [7:0] register_addr,
    output logic [7:0] write_data
);

    typedef enum logic [2:0]
    {
        C_IDLE,
        C_WP_CLEAR,
        C_HOST_WR,
        C_HOST_RD,
        C_POLL_SEC,
        C_POLL_MIN,
        C_POLL_HR
    } ctrl_t;

    ctrl_t       state;
    logic [15:0] idle_count;
    logic        wp_clear;      // chip known to be writable
    logic [4:0]  host_addr;
    logic [7:0]  host_wdata;
    logic [7:0]  sec_buf;
    logic [7:0]  min_buf;
    logic [4:0]  xfer_reg;
    logic        xfer_read;
    logic        poll_due;
    logic        accept;

    assign busy     = (state != C_IDLE);
    assign poll_due = (idle_count == ds_pkg::POLL_CYCLES);
    assign accept   = (state == C_IDLE) && (req_write || req_read);

    // register and direction of the transfer in flight
    always_comb
    begin
        xfer_reg  = host_addr;
        xfer_read = 1'b0;
        case (state)
            C_WP_CLEAR: xfer_reg = ds_pkg::REG_CONTROL;
            C_HOST_RD:  xfer_read = 1'b1;
            C_POLL_SEC:
            begin
                xfer_reg  = ds_pkg::REG_SECONDS;
                xfer_read = 1'b1;
            end
            C_POLL_MIN:
            begin
                xfer_reg  = ds_pkg::REG_MINUTES;
                xfer_read = 1'b1;
            end
            C_POLL_HR:
            begin
                xfer_reg  = ds_pkg::REG_HOURS;
                xfer_read = 1'b1;
            end
            default: xfer_reg = host_addr;
        endcase
    end

    always_comb
    begin
        func_start = 2'b00;
        if (busy && !func_done)     // dropped in the done cycle, engine stays idle
        begin
            if (xfer_read)
            begin
                func_start[ds_pkg::FUNC_READ] = 1'b1;
            end
            else
            begin
                func_start[ds_pkg::FUNC_WRITE] = 1'b1;
            end
        end
    end

    assign register_addr = ds_pkg::cmd_byte(xfer_reg, xfer_read);
    assign write_data    = (state == C_WP_CLEAR) ? 8'h00 : host_wdata;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= C_IDLE;
            idle_count  <= 16'd0;
            wp_clear    <= 1'b0;            // chip powers up protected
            rdata_valid <= 1'b0;
            time_valid  <= 1'b0;
        end
        else
        begin
            rdata_valid <= 1'b0;
            time_valid  <= 1'b0;
            case (state)
                C_IDLE:
                begin
                    if (req_write)
                    begin
                        state      <= wp_clear ? C_HOST_WR : C_WP_CLEAR;
                        idle_count <= 16'd0;
                    end
                    else if (req_read)
                    begin
                        state      <= C_HOST_RD;
                        idle_count <= 16'd0;
                    end
                    else if (poll_due)
                    begin
                        state      <= C_POLL_SEC;
                        idle_count <= 16'd0;
                    end
                    else
                    begin
                        idle_count <= idle_count + 16'd1;
                    end
                end

                C_WP_CLEAR:
                begin
                    if (func_done)
                    begin
                        wp_clear <= 1'b1;
                        state    <= C_HOST_WR;
                    end
                end

                C_HOST_WR:
                begin
                    if (func_done)
                    begin
                        if (host_addr == ds_pkg::REG_CONTROL)
                        begin
                            wp_clear <= !host_wdata[ds_pkg::WP_BIT];   // host may re-protect
                        end
                        state <= C_IDLE;
                    end
                end

                C_HOST_RD:
                begin
                    if (func_done)
                    begin
                        rdata_valid <= 1'b1;
                        state       <= C_IDLE;
                    end
                end

                C_POLL_SEC: if (func_done) state <= C_POLL_MIN;
                C_POLL_MIN: if (func_done) state <= C_POLL_HR;

                C_POLL_HR:
                begin
                    if (func_done)
                    begin
                        time_valid <= 1'b1;
                        state      <= C_IDLE;
                    end
                end

                default: state <= C_IDLE;
            endcase
        end
    end

    // request fields and read results
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            host_addr  <= req_addr;
            host_wdata <= req_wdata;
        end
        if (func_done)
        begin
            case (state)
                C_HOST_RD:  req_rdata <= read_data;
                C_POLL_SEC: sec_buf   <= read_data;
                C_POLL_MIN: min_buf   <= read_data;
                C_POLL_HR:
                begin
                    seconds <= sec_buf;      // all three change in one cycle
                    minutes <= min_buf;
                    hours   <= read_data;
                end
                default: req_rdata <= req_rdata;
            endcase
        end
    end

endmodule

/* src/ds_function.sv */
module ds_function
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] func_start,
    input  logic [7:0] register_addr,
    input  logic [7:0] write_data,
    output logic       func_done,
    output logic [7:0] read_data,
    output logic       sclk,
    output logic       ce,
    inout  wire        sio
);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_CMD,
        S_WDATA,
        S_TURN,
        S_RDATA,
        S_CE_LOW,
        S_DONE
    } step_t;

    step_t      step;
    logic [4:0] count;       // half-bit timer
    logic [2:0] bit_idx;     // bit within the current byte
    logic [7:0] shift;       // out: bit 0 on sio, in: filled from the top
    logic       sio_oe;
    logic       is_read;
    logic       held;
    logic       bit_phase;
    logic       half_end;

    assign held      = |func_start;
    assign bit_phase = (step == S_CMD) || (step == S_WDATA) || (step == S_RDATA);
    assign half_end  = (count == ds_pkg::HALF_BIT_LAST);

    assign sio = sio_oe ? shift[0] : 1'bz;

    // runs only inside the bit phases, so every half bit is full length
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= 5'd0;
        end
        else if (!held || !bit_phase || half_end)
        begin
            count <= 5'd0;
        end
        else
        begin
            count <= count + 5'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            step      <= S_IDLE;
            bit_idx   <= 3'd0;
            shift     <= 8'd0;
            sio_oe    <= 1'b1;
            is_read   <= 1'b0;
            sclk      <= 1'b0;
            ce        <= 1'b0;
            func_done <= 1'b0;
        end
        else
        begin
            func_done <= 1'b0;
            if (!held && step != S_IDLE)
            begin
                // request withdrawn mid transfer, park the bus
                step    <= S_IDLE;
                bit_idx <= 3'd0;
                shift   <= 8'd0;
                sio_oe  <= 1'b1;
                sclk    <= 1'b0;
                ce      <= 1'b0;
            end
            else
            begin
                case (step)
                    S_IDLE:
                    begin
                        if (held)
                        begin
                            ce      <= 1'b1;
                            sclk    <= 1'b0;
                            sio_oe  <= 1'b1;
                            shift   <= register_addr;   // bit 0 goes out first
                            is_read <= func_start[ds_pkg::FUNC_READ];
                            bit_idx <= 3'd0;
                            step    <= S_CMD;
                        end
                    end

                    S_CMD:
                    begin
                        if (half_end)
                        begin
                            if (!sclk)
                            begin
                                sclk <= 1'b1;           // chip samples here
                            end
                            else
                            begin
                                sclk    <= 1'b0;
                                bit_idx <= bit_idx + 3'd1;
                                if (bit_idx == 3'd7)
                                begin
                                    if (is_read)
                                    begin
                                        sio_oe <= 1'b0; // chip drives from this edge
                                        step   <= S_TURN;
                                    end
                                    else
                                    begin
                                        shift <= write_data;
                                        step  <= S_WDATA;
                                    end
                                end
                                else
                                begin
                                    shift <= {1'b0, shift[7:1]};
                                end
                            end
                        end
                    end

                    S_WDATA:
                    begin
                        if (half_end)
                        begin
                            if (!sclk)
                            begin
                                sclk <= 1'b1;
                            end
                            else
                            begin
                                sclk    <= 1'b0;
                                bit_idx <= bit_idx + 3'd1;
                                shift   <= {1'b0, shift[7:1]};
                                if (bit_idx == 3'd7)
                                begin
                                    step <= S_CE_LOW;
                                end
                            end
                        end
                    end

                    S_TURN:
                    begin
                        step <= S_RDATA;                // one cycle with sio released
                    end

                    S_RDATA:
                    begin
                        if (half_end)
                        begin
                            if (!sclk)
                            begin
                                sclk  <= 1'b1;
                                shift <= {sio, shift[7:1]};   // sample at end of low half
                            end
                            else
                            begin
                                sclk    <= 1'b0;
                                bit_idx <= bit_idx + 3'd1;
                                if (bit_idx == 3'd7)
                                begin
                                    step <= S_CE_LOW;
                                end
                            end
                        end
                    end

                    S_CE_LOW:
                    begin
                        ce     <= 1'b0;
                        sio_oe <= 1'b1;
                        shift  <= 8'd0;                 // idle bus held low
                        step   <= S_DONE;
                    end

                    S_DONE:
                    begin
                        func_done <= 1'b1;
                        step      <= S_IDLE;
                    end

                    default:
                    begin
                        step <= S_IDLE;
                    end
                endcase
            end
        end
    end

    // captured byte stays until the next read completes
    always_ff @(posedge clk)
    begin
        if (step == S_CE_LOW && is_read)
        begin
            read_data <= shift;
        end
    end

endmodule

/* src/ds_pkg.sv */
package ds_pkg;

    // three-wire bus timing
    localparam logic [4:0] HALF_BIT_LAST = 5'd24;   // 25 clocks per half bit

    // bit positions inside func_start
    localparam int FUNC_WRITE = 1;
    localparam int FUNC_READ  = 0;

    // command byte fields
    localparam logic [7:0] CMD_ALWAYS_ONE = 8'h80;  // bit 7 set on every command
    localparam logic [7:0] CMD_READ_BIT   = 8'h01;  // bit 0 selects read

    // clock/calendar register indices
    localparam logic [4:0] REG_SECONDS = 5'd0;
    localparam logic [4:0] REG_MINUTES = 5'd1;
    localparam logic [4:0] REG_HOURS   = 5'd2;
    localparam logic [4:0] REG_CONTROL = 5'd7;

    // write-protect flag in the control register
    localparam int WP_BIT = 7;

    // idle time before the next seconds/minutes/hours poll
    localparam logic [15:0] POLL_CYCLES = 16'd4000;

    // command byte: one, clock space, register index, read flag
    function automatic logic [7:0] cmd_byte
    (
        input logic [4:0] reg_idx,
        input logic       rd
    );
        logic [7:0] cmd;
        cmd = CMD_ALWAYS_ONE | {2'b00, reg_idx, 1'b0};
        if (rd)
        begin
            cmd = cmd | CMD_READ_BIT;
        end
        return cmd;
    endfunction

endpackage

/* verif/ds1302_model.sv */
module ds1302_model
(
    input  logic sclk,
    input  logic ce,
    inout  wire  sio
);

    logic [7:0] regs [0:31];
    logic [7:0] cmd;
    logic [7:0] data_in;
    logic [7:0] data_out;
    logic       sio_en;
    logic       sio_bit;
    int         bit_count;     // sclk rising edges since ce went high

    assign sio = sio_en ? sio_bit : 1'bz;

    initial
    begin
        int i;
        sio_en    = 1'b0;
        sio_bit   = 1'b0;
        bit_count = 0;
        cmd       = 8'h00;
        for (i = 0; i < 32; i++)
        begin
            regs[i] = 8'h40 | 8'(i);
        end
        regs[7] = 8'h80;           // powers up write-protected
    end

    // every ce edge starts or ends a transfer
    always @(posedge ce or negedge ce)
    begin
        bit_count = 0;
        sio_en    = 1'b0;
    end

    always @(posedge sclk)
    begin
        if (ce)
        begin
            if (bit_count < 8)
            begin
                cmd[bit_count] = sio;  // command comes LSB first
            end
            else if (bit_count < 16 && !cmd[0])
            begin
                data_in[bit_count - 8] = sio;
                // control register stays writable, the rest only with WP clear
                if (bit_count == 15 && cmd[7] && (cmd[5:1] == 5'd7 || !regs[7][7]))
                begin
                    regs[cmd[5:1]] = data_in;
                end
            end
            bit_count = bit_count + 1;
        end
    end

    // read data leaves on falling edges, starting at the end of the command
    always @(negedge sclk)
    begin
        if (ce && cmd[0] && bit_count >= 8 && bit_count < 16)
        begin
            if (bit_count == 8)
            begin
                data_out = regs[cmd[5:1]];
            end
            sio_bit = data_out[bit_count - 8];
            sio_en  = 1'b1;
        end
        else
        begin
            sio_en = 1'b0;         // released after the last data bit
        end
    end

endmodule

/* verif/ds1302_rtc_props.sv */
module ds1302_rtc_props
(
    input logic       clk,
    input logic       rst_n,
    input logic [1:0] func_start,
    input logic       func_done,
    input logic       sclk,
    input logic       ce
);

    ce_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        (func_start == 2'b00) |-> !ce)
        else $error("ce is high while no request is held");

    // a transfer only ends through the done pulse
    ce_end_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ce) |=> func_done)
        else $error("ce fell without a func_done pulse");

    // serial clock only moves inside a transfer
    sclk_inside_ce: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(sclk) |-> ce)
        else $error("sclk toggled while ce was low");

endmodule

bind ds_function ds1302_rtc_props props_i
(
    .clk        (clk),
    .rst_n      (rst_n),
    .func_start (func_start),
    .func_done  (func_done),
    .sclk       (sclk),
    .ce         (ce)
);

/* verif/ds1302_rtc_tb.sv */
module ds1302_rtc_tb;

    localparam int OP_LIMIT        = 3000;     // a write with the inserted clear fits easily
    localparam int XFER_TOTAL      = 51;       // transfers over all tests
    localparam int POLL_LIMIT      = ds_pkg::POLL_CYCLES + 4000;
    localparam int WATCHDOG_CYCLES = XFER_TOTAL * 2000 + 3 * ds_pkg::POLL_CYCLES;

    logic       clk;
    logic       rst_n;
    logic       req_write;
    logic       req_read;
    logic [4:0] req_addr;
    logic [7:0] req_wdata;
    logic       busy;
    logic [7:0] req_rdata;
    logic       rdata_valid;
    logic [7:0] seconds;
    logic [7:0] minutes;
    logic [7:0] hours;
    logic       time_valid;
    logic       sclk;
    logic       ce;
    wire        sio;

    logic [7:0]  ref_regs [0:31];   // expected chip contents
    logic [31:0] lcg_state;
    logic [4:0]  written [$];
    int          exp_xfers;
    int          ce_rises;
    int          errors;
    int          test_start;

    tb_clock_gen clock_gen_i
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ds1302_rtc ds1302_rtc_i
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_write   (req_write),
        .req_read    (req_read),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .busy        (busy),
        .req_rdata   (req_rdata),
        .rdata_valid (rdata_valid),
        .seconds     (seconds),
        .minutes     (minutes),
        .hours       (hours),
        .time_valid  (time_valid),
        .sclk        (sclk),
        .ce          (ce),
        .sio         (sio)
    );

    ds1302_model rtc_chip_i
    (
        .sclk (sclk),
        .ce   (ce),
        .sio  (sio)
    );

    always @(posedge ce)
    begin
        ce_rises = ce_rises + 1;    // one per transfer on the wire
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Error %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_failure(input string text);
        $display("%s", text);
        errors++;
    endtask

    task automatic end_test(input string name);
        $display("%s finished with %0d error(s)", name, errors - test_start);
        test_start = errors;
    endtask

    // chip side effect of one host write, clear inserted while protected
    task automatic expect_host_write(input logic [4:0] addr, input logic [7:0] data);
        if (ref_regs[ds_pkg::REG_CONTROL][ds_pkg::WP_BIT])
        begin
            ref_regs[ds_pkg::REG_CONTROL] = 8'h00;
            exp_xfers++;
        end
        if (addr == ds_pkg::REG_CONTROL || !ref_regs[ds_pkg::REG_CONTROL][ds_pkg::WP_BIT])
        begin
            ref_regs[addr] = data;
        end
        exp_xfers++;
    endtask

    task automatic host_write(input logic [4:0] addr, input logic [7:0] data);
        int cycles;
        @(posedge clk);
        req_write <= 1'b1;
        req_addr  <= addr;
        req_wdata <= data;
        @(posedge clk);
        req_write <= 1'b0;
        @(negedge clk);
        if (!busy)
        begin
            report_failure($sformatf("write to register %0d was not accepted", addr));
        end
        cycles = 0;
        while (busy && cycles < OP_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (busy)
        begin
            report_failure($sformatf("write to register %0d never finished", addr));
        end
        expect_host_write(addr, data);
    endtask

    task automatic issue_read(input logic [4:0] addr);
        @(posedge clk);
        req_read <= 1'b1;
        req_addr <= addr;
        @(posedge clk);
        req_read <= 1'b0;
        exp_xfers++;
    endtask

    task automatic wait_read_data(output logic [7:0] data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rdata_valid && cycles < OP_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!rdata_valid)
        begin
            report_failure("host read returned no data in time");
        end
        data = req_rdata;
    endtask

    task automatic host_read(input logic [4:0] addr, output logic [7:0] data);
        issue_read(addr);
        wait_read_data(data);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d clocks, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        logic [7:0] rd;
        logic [7:0] data;
        logic [4:0] addr;
        int         cycles;
        int         n;
        req_write  = 1'b0;
        req_read   = 1'b0;
        req_addr   = 5'd0;
        req_wdata  = 8'd0;
        lcg_state  = 32'd50105;
        exp_xfers  = 0;
        ce_rises   = 0;
        errors     = 0;
        test_start = 0;
        for (n = 0; n < 32; n++)
        begin
            ref_regs[n] = 8'h40 | 8'(n);
        end
        ref_regs[ds_pkg::REG_CONTROL] = 8'h80;

        @(posedge rst_n);
        @(negedge clk);
        check_value("reset_state ce", 0, ce);
        check_value("reset_state sclk", 0, sclk);
        check_value("reset_state sio", 0, sio);
        check_value("reset_state busy", 0, busy);
        check_value("reset_state rdata_valid", 0, rdata_valid);
        check_value("reset_state time_valid", 0, time_valid);
        end_test("reset_state");

        // chip ignores this write unless the controller clears WP first
        addr = 5'((next_random() >> 16) % 7);
        data = 8'(next_random() >> 16);
        host_write(addr, data);
        written.push_back(addr);
        check_value("wp_insertion chip", data, rtc_chip_i.regs[addr]);
        host_read(ds_pkg::REG_CONTROL, rd);
        check_value("wp_insertion control", ref_regs[ds_pkg::REG_CONTROL], rd);
        end_test("wp_insertion");

        for (n = 0; n < 20; n++)
        begin
            addr = 5'((next_random() >> 16) % 7);
            data = 8'(next_random() >> 16);
            host_write(addr, data);
            written.push_back(addr);
            addr = written[(next_random() >> 16) % written.size()];
            host_read(addr, rd);
            check_value($sformatf("random_wr_rd reg %0d", addr), ref_regs[addr], rd);
        end
        end_test("random_wr_rd");

        host_write(ds_pkg::REG_CONTROL, 8'h80);
        addr = 5'((next_random() >> 16) % 7);
        data = 8'(next_random() >> 16);
        host_write(addr, data);
        host_read(addr, rd);
        check_value("reprotect", ref_regs[addr], rd);
        end_test("reprotect");

        // bus left idle until the poll runs
        exp_xfers = exp_xfers + 3;
        cycles = 0;
        @(negedge clk);
        while (!time_valid && cycles < POLL_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!time_valid)
        begin
            report_failure("no time poll seen while the bus was idle");
        end
        check_value("time_poll seconds", ref_regs[ds_pkg::REG_SECONDS], seconds);
        check_value("time_poll minutes", ref_regs[ds_pkg::REG_MINUTES], minutes);
        check_value("time_poll hours", ref_regs[ds_pkg::REG_HOURS], hours);
        end_test("time_poll");

        addr = written[0];
        issue_read(addr);
        @(negedge clk);
        if (!busy)
        begin
            report_failure("controller not busy during a host read");
        end
        @(posedge clk);
        req_write <= 1'b1;           // must be dropped, controller is busy
        req_addr  <= 5'd3;
        req_wdata <= 8'(next_random() >> 16);
        @(posedge clk);
        req_write <= 1'b0;
        wait_read_data(rd);
        check_value("busy_rule rdata", ref_regs[addr], rd);
        repeat (50) @(negedge clk);
        check_value("busy_rule busy", 0, busy);
        check_value("busy_rule transfers", exp_xfers, ce_rises);
        end_test("busy_rule");

        $display("tests 6, transfers %0d, errors %0d", ce_rises, errors);
        if (errors == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen
(
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 50;   // 100 time units per clock
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule
